/* rtl/rv_pkg.sv */
package rv_pkg;

    localparam int xlen = 64;

    typedef logic [31:0] inst_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    // funct3 of the alu groups (OP and OP-IMM)
    typedef enum logic [2:0] {
        f3_add, f3_sll, f3_slt, f3_sltu, f3_xor, f3_sr, f3_or, f3_and
    } alu_funct3_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [2:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
    } br_type_e;

    typedef enum logic [1:0] {wb_none, wb_alu, wb_link, wb_load} wb_sel_e;

    // all zero is a bubble
    typedef struct packed {
        alu_op_e  alu_op;
        logic     a_sel_pc;   // operand a is pc instead of rs1
        logic     b_sel_imm;  // operand b is imm instead of rs2
        br_type_e br_type;
        logic     jump;
        logic     jalr;
        logic     mem_rd;
        logic     mem_wr;
        wb_sel_e  wb_sel;
        logic     reg_wr;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_t           inst;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        ctrl_t           ctrl;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        logic [4:0]      rd;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] pc_plus4;
        ctrl_t           ctrl;
        logic [xlen-1:0] alu_res;
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
    } ex_mem_t;

    typedef struct packed {
        logic            reg_wr;
        logic [4:0]      rd;
        logic [xlen-1:0] value;
    } mem_wb_t;

endpackage

/* rtl/rf_write_if.sv */
interface rf_write_if;
    import rv_pkg::*;

    logic            wr_en;  // instruction writes a register
    logic [4:0]      rd;
    logic [xlen-1:0] data;
    logic            valid;  // destination is a writable register

    modport source (
        output wr_en,
        output rd,
        output data,
        output valid
    );

    modport sink (
        input wr_en,
        input rd,
        input data,
        input valid
    );

endinterface

/* rtl/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // zero payload carries a zero ctrl, i.e. a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;  // squash the younger instruction
        end else begin
            q <= d;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
module fetch_unit #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    redirect,
    input  logic [rv_pkg::xlen-1:0] redirect_pc,
    output logic [rv_pkg::xlen-1:0] pc
);
    import rv_pkg::*;

    logic [xlen-1:0] pc_next;

    // taken branch or jump from execute wins over sequential fetch
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = pc + xlen'(4);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // targets come from execute; software keeps them word aligned
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (rst)
        redirect |-> (redirect_pc[1:0] == 2'b00)
    ) else $error("misaligned redirect target %h", redirect_pc);

endmodule

/* rtl/decoder.sv */
module decoder (
    input  rv_pkg::inst_t           inst,
    output rv_pkg::ctrl_t           ctrl,
    output logic [rv_pkg::xlen-1:0] imm,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd
);
    import rv_pkg::*;

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic            is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic            is_load, is_store, is_opimm, is_op;
    logic            shift_ok;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (alu_funct3_e'(f3))
            f3_add:  return alt ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return alt ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            default: return alu_and;
        endcase
    endfunction

    function automatic br_type_e br_sel(input logic [2:0] f3);
        case (f3)
            3'b000:  return br_eq;
            3'b001:  return br_ne;
            3'b100:  return br_lt;
            3'b101:  return br_ge;
            3'b110:  return br_ltu;
            3'b111:  return br_geu;
            default: return br_none;
        endcase
    endfunction

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // 6-bit shamt; only srai may set bit 30
    assign shift_ok = (funct3 == 3'b001) ? (inst[31:26] == 6'b000000) :
                      (funct3 == 3'b101) ? (inst[31:26] == {1'b0, inst[30], 4'b0000}) : 1'b1;

    assign is_lui    = (inst[6:0] == op_lui);
    assign is_auipc  = (inst[6:0] == op_auipc);
    assign is_jal    = (inst[6:0] == op_jal);
    assign is_jalr   = (inst[6:0] == op_jalr) && (funct3 == 3'b000);
    assign is_branch = (inst[6:0] == op_branch) && (funct3[2:1] != 2'b01);
    assign is_load   = (inst[6:0] == op_load) && (funct3 == 3'b011);  // ld only
    assign is_store  = (inst[6:0] == op_store) && (funct3 == 3'b011); // sd only
    assign is_opimm  = (inst[6:0] == op_imm) && shift_ok;
    assign is_op     = (inst[6:0] == op_reg) && ((funct7 == 7'b0000000) ||
                       ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101)));

    always_comb begin
        ctrl = '0;  // unknown opcode stays a no-op
        if (is_op) begin
            ctrl.alu_op = alu_sel(funct3, inst[30]);
        end else if (is_opimm) begin
            ctrl.alu_op = alu_sel(funct3, (funct3 == 3'b101) && inst[30]);
        end else if (is_lui) begin
            ctrl.alu_op = alu_pass_b;
        end
        ctrl.a_sel_pc  = is_auipc;
        ctrl.b_sel_imm = is_lui || is_auipc || is_opimm || is_load || is_store;
        if (is_branch) begin
            ctrl.br_type = br_sel(funct3);
        end
        ctrl.jump   = is_jal || is_jalr;
        ctrl.jalr   = is_jalr;
        ctrl.mem_rd = is_load;
        ctrl.mem_wr = is_store;
        if (is_jal || is_jalr) begin
            ctrl.wb_sel = wb_link;
        end else if (is_load) begin
            ctrl.wb_sel = wb_load;
        end else if (is_lui || is_auipc || is_op || is_opimm) begin
            ctrl.wb_sel = wb_alu;
        end
        ctrl.reg_wr = (ctrl.wb_sel != wb_none);
    end

    always_comb begin
        if (is_lui || is_auipc) begin
            imm = imm_u;
        end else if (is_jal) begin
            imm = imm_j;
        end else if (is_branch) begin
            imm = imm_b;
        end else if (is_store) begin
            imm = imm_s;
        end else begin
            imm = imm_i;  // jalr, loads, op-imm
        end
    end

endmodule

/* rtl/reg_file.sv */
module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [rv_pkg::xlen-1:0] rd1,
    output logic [rv_pkg::xlen-1:0] rd2,
    rf_write_if.sink                wr
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31];  // no storage for x0
    logic            commit;

    assign commit = wr.wr_en && wr.valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (commit) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // write-first, so write-back and decode can share a cycle
    always_comb begin
        rd1 = '0;
        if (rs1 != 5'd0) begin
            rd1 = (commit && wr.rd == rs1) ? wr.data : regs[rs1];
        end
    end

    always_comb begin
        rd2 = '0;
        if (rs2 != 5'd0) begin
            rd2 = (commit && wr.rd == rs2) ? wr.data : regs[rs2];
        end
    end

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (rst)
        commit |-> (wr.rd != 5'd0)
    ) else $error("register write committed to x0");

endmodule

/* rtl/alu.sv */
module alu (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] y
);
    import rv_pkg::*;

    logic [5:0] shamt;

    assign shamt = b[5:0];  // rv64 shifts use 6 bits

    always_comb begin
        case (op)
            alu_add:    y = a + b;
            alu_sub:    y = a - b;
            alu_sll:    y = a << shamt;
            alu_slt:    y = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            alu_sltu:   y = {{(xlen-1){1'b0}}, (a < b)};
            alu_xor:    y = a ^ b;
            alu_srl:    y = a >> shamt;
            alu_sra:    y = $signed(a) >>> shamt;
            alu_or:     y = a | b;
            alu_and:    y = a & b;
            alu_pass_b: y = b;  // lui
            default:    y = '0;
        endcase
    end

endmodule

/* rtl/execute_unit.sv */
module execute_unit (
    input  rv_pkg::id_ex_t          stage,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    redirect,
    output logic [rv_pkg::xlen-1:0] redirect_pc
);
    import rv_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] jalr_sum;
    logic            taken;

    assign op_a = stage.ctrl.a_sel_pc ? stage.pc : stage.rs1_val;
    assign op_b = stage.ctrl.b_sel_imm ? stage.imm : stage.rs2_val;

    alu u_alu (
        .op (stage.ctrl.alu_op),
        .a  (op_a),
        .b  (op_b),
        .y  (result)
    );

    // branch condition always compares the two register values
    always_comb begin
        case (stage.ctrl.br_type)
            br_eq:   taken = (stage.rs1_val == stage.rs2_val);
            br_ne:   taken = (stage.rs1_val != stage.rs2_val);
            br_lt:   taken = ($signed(stage.rs1_val) < $signed(stage.rs2_val));
            br_ge:   taken = ($signed(stage.rs1_val) >= $signed(stage.rs2_val));
            br_ltu:  taken = (stage.rs1_val < stage.rs2_val);
            br_geu:  taken = (stage.rs1_val >= stage.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = stage.ctrl.jump || taken;
    assign jalr_sum = stage.rs1_val + stage.imm;

    always_comb begin
        if (stage.ctrl.jalr) begin
            redirect_pc = {jalr_sum[xlen-1:1], 1'b0};  // bit 0 cleared
        end else begin
            redirect_pc = stage.pc + stage.imm;  // jal and branches
        end
    end

endmodule

/* rtl/mem_access.sv */
module mem_access (
    input  rv_pkg::ex_mem_t         stage,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    dmem_wr,
    output logic                    dmem_rd,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata,
    output rv_pkg::mem_wb_t         wb
);
    import rv_pkg::*;

    // address is the alu sum rs1 + imm
    assign dmem_addr  = stage.alu_res;
    assign dmem_wdata = stage.store_data;
    assign dmem_wr    = stage.ctrl.mem_wr;
    assign dmem_rd    = stage.ctrl.mem_rd;

    always_comb begin
        wb.reg_wr = stage.ctrl.reg_wr;
        wb.rd     = stage.rd;
        case (stage.ctrl.wb_sel)
            wb_alu:  wb.value = stage.alu_res;
            wb_link: wb.value = stage.pc_plus4;
            wb_load: wb.value = dmem_rdata;  // read data is combinational
            default: wb.value = '0;
        endcase
    end

    // decode never marks one instruction as both a load and a store
    always_comb begin
        a_rd_wr_excl: assert (!(dmem_wr && dmem_rd))
            else $error("data port read and write in the same cycle");
    end

endmodule

/* rtl/rv_core.sv */
module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    output logic [rv_pkg::xlen-1:0] imem_addr,
    input  rv_pkg::inst_t           imem_data,
    output logic [rv_pkg::xlen-1:0] dmem_addr,
    output logic [rv_pkg::xlen-1:0] dmem_wdata,
    output logic                    dmem_wr,
    output logic                    dmem_rd,
    input  logic [rv_pkg::xlen-1:0] dmem_rdata
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic            redirect;
    logic [xlen-1:0] redirect_pc;
    if_id_t          if_id_d, if_id_q;
    id_ex_t          id_ex_d, id_ex_q;
    ex_mem_t         ex_mem_d, ex_mem_q;
    mem_wb_t         mem_wb_d, mem_wb_q;
    ctrl_t           dec_ctrl;
    logic [xlen-1:0] dec_imm;
    logic [4:0]      dec_rs1, dec_rs2, dec_rd;
    logic [xlen-1:0] rs1_val, rs2_val;
    logic [xlen-1:0] ex_result;

    rf_write_if rf_wr ();

    fetch_unit #(.reset_pc(reset_pc)) u_fetch (
        .clk, .rst, .redirect, .redirect_pc, .pc
    );

    assign imem_addr = pc;
    assign if_id_d   = '{pc: pc, inst: imem_data};

    // taken redirect kills what sits in fetch and decode
    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk, .rst, .flush(redirect), .d(if_id_d), .q(if_id_q)
    );

    decoder u_dec (
        .inst(if_id_q.inst), .ctrl(dec_ctrl), .imm(dec_imm),
        .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd)
    );

    reg_file u_rf (
        .clk, .rst, .rs1(dec_rs1), .rs2(dec_rs2),
        .rd1(rs1_val), .rd2(rs2_val), .wr(rf_wr.sink)
    );

    assign id_ex_d = '{pc: if_id_q.pc, ctrl: dec_ctrl, rs1_val: rs1_val,
                       rs2_val: rs2_val, imm: dec_imm, rd: dec_rd};

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk, .rst, .flush(redirect), .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit u_ex (
        .stage(id_ex_q), .result(ex_result), .redirect, .redirect_pc
    );

    assign ex_mem_d = '{pc_plus4: id_ex_q.pc + xlen'(4), ctrl: id_ex_q.ctrl,
                        alu_res: ex_result, store_data: id_ex_q.rs2_val, rd: id_ex_q.rd};

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk, .rst, .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    mem_access u_mem (
        .stage(ex_mem_q), .dmem_addr, .dmem_wdata, .dmem_wr, .dmem_rd,
        .dmem_rdata, .wb(mem_wb_d)
    );

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk, .rst, .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    // write-back side of the register write port
    assign rf_wr.wr_en = mem_wb_q.reg_wr;
    assign rf_wr.rd    = mem_wb_q.rd;
    assign rf_wr.data  = mem_wb_q.value;
    assign rf_wr.valid = (mem_wb_q.rd != 5'd0);  // writes to x0 are dropped

endmodule

/* tests/tb_rv_core.sv */
module tb_rv_core;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_pkg::*;

    localparam logic [xlen-1:0] reset_pc = 64'h40;  // program starts away from address zero
    localparam int reset_cycles   = 16;
    localparam int budget_alu     = 100;
    localparam int budget_mem     = 50;
    localparam int budget_branch  = 80;
    localparam int budget_jump    = 50;
    localparam int budget_random  = 260;
    localparam int n_tests        = 5;
    // a few extra cycles per test cover the reset entry edge
    localparam int cycle_limit = budget_alu + budget_mem + budget_branch + budget_jump
                               + budget_random + n_tests * (reset_cycles + 4);

    logic            clk;
    logic            rst;
    logic [xlen-1:0] imem_addr;
    inst_t           imem_data;
    logic [xlen-1:0] dmem_addr;
    logic [xlen-1:0] dmem_wdata;
    logic            dmem_wr;
    logic            dmem_rd;
    logic [xlen-1:0] dmem_rdata;

    inst_t           imem [256];
    logic [xlen-1:0] dmem [256];
    logic [xlen-1:0] st_addr_q[$];
    logic [xlen-1:0] st_data_q[$];
    logic [xlen-1:0] exp_addr_q[$];
    logic [xlen-1:0] exp_data_q[$];
    int              wp;  // next instruction slot
    int              errors;
    int              checks;
    int              cycle_count;
    int              seed = 32'hfd7a_a6f4;

    rv_core #(.reset_pc(reset_pc)) u_dut (
        .clk, .rst, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata,
        .dmem_wr, .dmem_rd, .dmem_rdata
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem_rd ? dmem[dmem_addr[10:3]] : '0;  // answers only a read strobe

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped by the cycle limit after %0d cycles", cycle_count);
        $display("tests failed");
        $finish;
    end

    // instruction encoders
    function automatic inst_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic inst_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic inst_t enc_s(int imm, int rs2, int rs1);
        logic [11:0] s;
        s = 12'(imm);
        return {s[11:5], 5'(rs2), 5'(rs1), 3'b011, s[4:0], 7'b0100011};
    endfunction

    function automatic inst_t enc_b(int imm, int f3, int rs1, int rs2);
        logic [12:0] b;
        b = 13'(imm);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'(f3), b[4:1], b[11], 7'b1100011};
    endfunction

    function automatic inst_t enc_u(int imm20, int rd, logic [6:0] op);
        return {20'(imm20), 5'(rd), op};
    endfunction

    function automatic inst_t enc_j(int imm, int rd);
        logic [20:0] j;
        j = 21'(imm);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'b1101111};
    endfunction

    // branch outcome straight from the isa conditions
    function automatic logic branch_taken(int f3, logic [xlen-1:0] x, logic [xlen-1:0] y);
        case (f3)
            0:       return x == y;
            1:       return x != y;
            4:       return $signed(x) < $signed(y);
            5:       return $signed(x) >= $signed(y);
            6:       return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic emit(inst_t i);
        imem[wp] = i;
        wp++;
    endtask

    task automatic nops(int n);
        repeat (n) emit(enc_i(0, 0, 0, 0, op_imm));
    endtask

    task automatic addi(int rd, int rs1, int imm);
        emit(enc_i(imm, rs1, 0, rd, op_imm));
    endtask

    task automatic ld(int rd, int rs1, int off);
        emit(enc_i(off, rs1, 3, rd, op_load));
    endtask

    task automatic sd(int rs2, int rs1, int off);
        emit(enc_s(off, rs2, rs1));
    endtask

    task automatic halt();
        emit(enc_j(0, 0));  // jump to itself
    endtask

    task automatic expect_store(logic [xlen-1:0] addr, logic [xlen-1:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    task automatic compare_data(logic [xlen-1:0] got, logic [xlen-1:0] exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s data is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(logic [xlen-1:0] got, logic [xlen-1:0] exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s address is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(0, 0, 0, 0, op_imm);
            dmem[i] = '0;
        end
    endtask

    task automatic start_test();
        @(negedge clk);
        rst = 1'b1;
        clear_memories();
        st_addr_q.delete();
        st_data_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        wp = int'(reset_pc[9:2]);
    endtask

    task automatic release_reset();
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
            compare_bit(dmem_wr, 1'b0, "dmem_wr in reset");
            compare_bit(dmem_rd, 1'b0, "dmem_rd in reset");
            compare_addr(imem_addr, reset_pc, "fetch in reset");
        end
        rst = 1'b0;
        compare_addr(imem_addr, reset_pc, "first fetch");
    endtask

    // port sampled mid-cycle so the store lands before the next edge
    task automatic advance_cycle();
        @(negedge clk);
        if (dmem_wr) begin
            dmem[dmem_addr[10:3]] = dmem_wdata;
            st_addr_q.push_back(dmem_addr);
            st_data_q.push_back(dmem_wdata);
        end
    endtask

    task automatic run_program(int cycles);
        release_reset();
        repeat (cycles) advance_cycle();
    endtask

    task automatic compare_stores(string name);
        int n;
        if (st_addr_q.size() != exp_addr_q.size()) begin
            errors++;
            $display("%s: %0d stores were recorded but %0d were expected",
                     name, st_addr_q.size(), exp_addr_q.size());
        end
        n = (st_addr_q.size() < exp_addr_q.size()) ? st_addr_q.size() : exp_addr_q.size();
        for (int i = 0; i < n; i++) begin
            compare_addr(st_addr_q[i], exp_addr_q[i], $sformatf("%s store %0d", name, i));
            compare_data(st_data_q[i], exp_data_q[i], $sformatf("%s store %0d", name, i));
        end
    endtask

    // one op into x5 and a store of x5 to the next slot
    task automatic alu_case(inst_t i, logic [xlen-1:0] exp);
        int slot;
        slot = exp_addr_q.size();
        emit(i);
        nops(2);
        sd(5, 0, 8 * slot);
        expect_store(64'(8 * slot), exp);
    endtask

    task automatic test_alu();
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] ci;
        logic [xlen-1:0] cn;
        start_test();
        a  = 64'(-1234);
        b  = 64'd13;
        ci = 64'd1955;
        cn = 64'(-300);
        addi(1, 0, -1234);
        addi(2, 0, 13);
        nops(2);
        alu_case(enc_r(0, 2, 1, 0, 5), a + b);
        alu_case(enc_r(32, 2, 1, 0, 5), a - b);
        alu_case(enc_r(0, 2, 1, 1, 5), a << b[5:0]);
        alu_case(enc_r(0, 2, 1, 2, 5), {63'd0, $signed(a) < $signed(b)});
        alu_case(enc_r(0, 2, 1, 3, 5), {63'd0, a < b});
        alu_case(enc_r(0, 2, 1, 4, 5), a ^ b);
        alu_case(enc_r(0, 2, 1, 5, 5), a >> b[5:0]);
        alu_case(enc_r(32, 2, 1, 5, 5), $signed(a) >>> b[5:0]);
        alu_case(enc_r(0, 2, 1, 6, 5), a | b);
        alu_case(enc_r(0, 2, 1, 7, 5), a & b);
        alu_case(enc_i(1955, 1, 0, 5, op_imm), a + ci);
        alu_case(enc_i(-300, 1, 2, 5, op_imm), {63'd0, $signed(a) < $signed(cn)});
        alu_case(enc_i(-300, 1, 3, 5, op_imm), {63'd0, a < cn});
        alu_case(enc_i(1955, 1, 4, 5, op_imm), a ^ ci);
        alu_case(enc_i(-300, 1, 6, 5, op_imm), a | cn);
        alu_case(enc_i(1955, 1, 7, 5, op_imm), a & ci);
        alu_case(enc_i(37, 1, 1, 5, op_imm), a << 37);
        alu_case(enc_i(37, 1, 5, 5, op_imm), a >> 37);
        alu_case(enc_i(1024 + 37, 1, 5, 5, op_imm), $signed(a) >>> 37);  // srai
        halt();
        run_program(budget_alu);
        compare_stores("alu");
    endtask

    task automatic test_load_store();
        logic [xlen-1:0] pre;
        start_test();
        pre = {32'($random(seed)), 32'($random(seed))};
        dmem[64] = pre;  // address 0x200
        addi(1, 0, 'h2ab);
        addi(2, 0, -5);
        nops(2);
        sd(1, 0, 'h100);
        sd(2, 0, 'h108);
        ld(3, 0, 'h100);
        ld(4, 0, 'h108);
        nops(2);
        emit(enc_r(0, 4, 3, 0, 5));
        ld(6, 0, 'h200);
        nops(2);
        addi(6, 6, 1);
        sd(5, 0, 'h110);
        sd(3, 0, 'h118);
        sd(6, 0, 'h208);
        halt();
        expect_store(64'h100, 64'h2ab);
        expect_store(64'h108, 64'(-5));
        expect_store(64'h110, 64'h2a6);
        expect_store(64'h118, 64'h2ab);
        expect_store(64'h208, pre + 64'd1);
        run_program(budget_mem);
        compare_stores("load/store");
    endtask

    task automatic test_branches();
        int f3;
        int ra;
        int rb;
        int n;
        logic [xlen-1:0] va;
        logic [xlen-1:0] vb;
        start_test();
        addi(1, 0, -3);
        addi(2, 0, 5);
        addi(3, 0, 'h5a);
        addi(4, 0, 'h77);
        nops(2);
        n = 0;
        for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? c : c + 2;
            for (int k = 0; k < 2; k++) begin
                ra = (k == 1 && c >= 2) ? 2 : 1;
                rb = (k == 0) ? 2 : 1;
                va = (ra == 1) ? 64'(-3) : 64'd5;
                vb = (rb == 1) ? 64'(-3) : 64'd5;
                emit(enc_b(12, f3, ra, rb));
                sd(3, 0, 'h300 + 16 * n);  // skipped when taken
                sd(3, 0, 'h308 + 16 * n);
                sd(4, 0, 'h400 + 8 * n);   // marker at the target
                if (!branch_taken(f3, va, vb)) begin
                    expect_store(64'('h300 + 16 * n), 64'h5a);
                    expect_store(64'('h308 + 16 * n), 64'h5a);
                end
                expect_store(64'('h400 + 8 * n), 64'h77);
                n++;
            end
        end
        halt();
        run_program(budget_branch);
        compare_stores("branch");
    endtask

    task automatic test_jumps();
        int pc_auipc;
        int pc_jal;
        int pc_base;
        start_test();
        emit(enc_u('h12345, 1, op_lui));
        emit(enc_u('hfedcb, 2, op_lui));
        pc_auipc = wp * 4;
        emit(enc_u('h00010, 3, op_auipc));
        nops(2);
        sd(1, 0, 'h500);
        sd(2, 0, 'h508);
        sd(3, 0, 'h510);
        pc_jal = wp * 4;
        emit(enc_j(12, 5));
        sd(1, 0, 'h518);
        sd(1, 0, 'h520);
        nops(2);
        sd(5, 0, 'h528);
        pc_base = wp * 4;
        emit(enc_u(0, 6, op_auipc));
        nops(2);
        emit(enc_i(25, 6, 0, 7, op_jalr));  // odd target whose bit 0 is dropped
        sd(1, 0, 'h530);
        sd(1, 0, 'h538);
        nops(2);
        sd(7, 0, 'h540);
        halt();
        expect_store(64'h500, 64'h1234_5000);
        expect_store(64'h508, 64'hffff_ffff_fedc_b000);
        expect_store(64'h510, 64'(pc_auipc) + 64'h1_0000);
        expect_store(64'h528, 64'(pc_jal + 4));
        expect_store(64'h540, 64'(pc_base + 16));
        run_program(budget_jump);
        compare_stores("jump");
    endtask

    task automatic store_results(int j);
        for (int r = 0; r < 4; r++) begin
            sd(3 + r, 0, 'h100 + 32 * j + 8 * r);
        end
    endtask

    task automatic test_random_ops();
        logic [xlen-1:0] ra [20];
        logic [xlen-1:0] rb [20];
        start_test();
        for (int i = 0; i < 20; i++) begin
            ra[i] = {32'($random(seed)), 32'($random(seed))};
            rb[i] = {32'($random(seed)), 32'($random(seed))};
            dmem[128 + 2 * i] = ra[i];
            dmem[129 + 2 * i] = rb[i];
        end
        // loads of one pair overlap the stores of the previous one
        for (int i = 0; i < 20; i++) begin
            ld(1, 0, 'h400 + 16 * i);
            ld(2, 0, 'h408 + 16 * i);
            if (i == 0) begin
                nops(2);
            end else begin
                store_results(i - 1);
            end
            emit(enc_r(0, 2, 1, 0, 3));
            emit(enc_r(32, 2, 1, 0, 4));
            emit(enc_r(0, 2, 1, 4, 5));
            emit(enc_r(0, 2, 1, 3, 6));
        end
        store_results(19);
        halt();
        for (int i = 0; i < 20; i++) begin
            expect_store(64'('h100 + 32 * i), ra[i] + rb[i]);
            expect_store(64'('h108 + 32 * i), ra[i] - rb[i]);
            expect_store(64'('h110 + 32 * i), ra[i] ^ rb[i]);
            expect_store(64'('h118 + 32 * i), {63'd0, ra[i] < rb[i]});
        end
        run_program(budget_random);
        compare_stores("random");
    endtask

    initial begin
        rst    = 1'b1;
        errors = 0;
        checks = 0;
        wp     = 0;
        clear_memories();
        test_alu();
        test_load_store();
        test_branches();
        test_jumps();
        test_random_ops();
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
rtl/rv_pkg.sv
rtl/rf_write_if.sv
rtl/pipe_reg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/execute_unit.sv
rtl/mem_access.sv
rtl/rv_core.sv
tests/tb_rv_core.sv

/* Makefile */
# Verilator build and run of the core testbench

VERILATOR       ?= verilator
TOP             ?= tb_rv_core
FILELIST        ?= filelist.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
PASS_TEXT       ?= all tests passed
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
